//--- Makefile
TOP = ig_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f hw/*.sv tb/*.sv
	verilator --binary --assert -Wno-fatal -j 0 --top-module $(TOP) -f tb.f -Mdir obj_dir

# pass only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hw/ig_grad_calc.sv
module ig_grad_calc #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pix_valid,
    output logic                    pix_ready,
    input  ig_img_pkg::pixel_t      pix_data,
    input  ig_img_pkg::coord_t      pix_x,
    input  ig_img_pkg::coord_t      pix_y,
    output logic                    g_valid,
    input  logic                    g_ready,
    output ig_grad_pkg::grad_word_u g_word,
    output ig_img_pkg::addr_t       g_addr
);

    localparam ig_img_pkg::coord_t X_LAST = ig_img_pkg::coord_t'(IMG_W - 1);
    localparam ig_img_pkg::coord_t Y_LAST = ig_img_pkg::coord_t'(IMG_H - 1);

    // line buffer index width
    localparam int XW = (IMG_W > 1) ? $clog2(IMG_W) : 1;

    // unsigned pixels widened to signed 10 bits before subtracting
    function automatic ig_grad_pkg::grad_t pix_diff(
        input ig_img_pkg::pixel_t a,
        input ig_img_pkg::pixel_t b
    );
        ig_grad_pkg::grad_t sa;
        ig_grad_pkg::grad_t sb;
        sa = ig_grad_pkg::grad_t'({2'b00, a});
        sb = ig_grad_pkg::grad_t'({2'b00, b});
        return sa - sb;
    endfunction

    // previous row, entry x holds pixel (x, y-1)
    ig_img_pkg::pixel_t line_buf [IMG_W];

    logic                    flushing;
    ig_img_pkg::coord_t      fx;
    ig_img_pkg::addr_t       emit_addr;
    logic                    out_free;
    logic                    pix_acc;
    logic                    emit_pix;
    logic                    emit_flush;
    logic                    emit;
    ig_img_pkg::coord_t      sel_x;
    ig_img_pkg::coord_t      right_x;
    logic [XW-1:0]           idx;
    logic [XW-1:0]           right_idx;
    ig_img_pkg::pixel_t      up;
    ig_img_pkg::pixel_t      right;
    ig_grad_pkg::grad_word_u next_word;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign out_free   = !g_valid || g_ready;
    assign pix_ready  = !flushing && out_free;
    assign pix_acc    = pix_valid && pix_ready;
    // row 0 only fills the buffer
    assign emit_pix   = pix_acc && (pix_y != '0);
    assign emit_flush = flushing && out_free;
    assign emit       = emit_pix || emit_flush;

    // ----------------------------------------
    // subtractors
    // ----------------------------------------
    assign sel_x     = flushing ? fx : pix_x;
    assign right_x   = (sel_x == X_LAST) ? sel_x : sel_x + 1'b1;
    assign idx       = sel_x[XW-1:0];
    assign right_idx = right_x[XW-1:0];
    assign up        = line_buf[idx];
    assign right     = line_buf[right_idx];

    always_comb begin
        if (sel_x == X_LAST) begin
            next_word.f.gx = '0;
        end else begin
            next_word.f.gx = pix_diff(right, up);
        end
        // flushed row is the last one, nothing below it
        if (flushing) begin
            next_word.f.gy = '0;
        end else begin
            next_word.f.gy = pix_diff(pix_data, up);
        end
    end

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            g_valid   <= 1'b0;
            flushing  <= 1'b0;
            fx        <= '0;
            emit_addr <= '0;
        end else begin
            if (emit) begin
                g_valid <= 1'b1;
            end else if (g_ready) begin
                g_valid <= 1'b0;
            end
            // last pixel of the image completes the buffer
            if (pix_acc && pix_x == X_LAST && pix_y == Y_LAST) begin
                flushing <= 1'b1;
                fx       <= '0;
            end
            if (emit_flush) begin
                fx <= fx + 1'b1;
                if (fx == X_LAST) begin
                    flushing <= 1'b0;
                end
            end
            // words leave in raster order, restart after the flush
            if (emit_flush && fx == X_LAST) begin
                emit_addr <= '0;
            end else if (emit) begin
                emit_addr <= emit_addr + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // buffer and output word
    // ----------------------------------------
    always_ff @(posedge clk) begin
        // entry x is read before this write lands
        if (pix_acc) begin
            line_buf[pix_x[XW-1:0]] <= pix_data;
        end
        if (emit) begin
            g_word <= next_word;
            g_addr <= emit_addr;
        end
    end

endmodule

//--- hw/ig_grad_pkg.sv
package ig_grad_pkg;

    // ----------------------------------------
    // gradient fields
    // ----------------------------------------

    // one signed difference, range -255..255
    localparam int GRAD_W = 10;

    // full memory word, gx on top
    localparam int WORD_W = 2 * GRAD_W;

    typedef logic signed [GRAD_W-1:0] grad_t;

    typedef struct packed {
        grad_t gx;
        grad_t gy;
    } grad_fields_t;

    // ----------------------------------------
    // gradient word
    // ----------------------------------------

    // compute side fills f, memory side sees raw
    typedef union packed {
        logic [WORD_W-1:0] raw;
        grad_fields_t      f;
    } grad_word_u;

endpackage

//--- hw/ig_grad_store.sv
module ig_grad_store #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     g_valid,
    output logic                     g_ready,
    input  ig_grad_pkg::grad_word_u  g_word,
    input  ig_img_pkg::addr_t        g_addr,
    output logic                     grad_wr,
    output ig_img_pkg::addr_t        grad_addr,
    output logic [ig_grad_pkg::WORD_W-1:0] grad_do,
    input  logic                     grad_ready,
    output logic                     done
);

    // address of the final pixel
    localparam ig_img_pkg::addr_t LAST_ADDR = ig_img_pkg::addr_t'(IMG_W * IMG_H - 1);

    ig_grad_pkg::grad_word_u word_q;
    logic                    wr_done;
    logic                    accept;

    // ----------------------------------------
    // output register
    // ----------------------------------------

    // write completes on the memory handshake
    assign wr_done = grad_wr && grad_ready;

    // take a new word when empty or when the held one is leaving
    assign g_ready = !grad_wr || grad_ready;
    assign accept  = g_valid && g_ready;

    // memory sees the flat word
    assign grad_do = word_q.raw;

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            done    <= 1'b0;
        end else begin
            if (g_ready) begin
                grad_wr <= g_valid;
            end
            // one pulse after the last address is written
            done <= wr_done && (grad_addr == LAST_ADDR);
        end
    end

    // word and address hold while grad_ready is low
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q    <= g_word;
            grad_addr <= g_addr;
        end
    end

endmodule

//--- hw/ig_img_pkg.sv
package ig_img_pkg;

    // ----------------------------------------
    // image geometry
    // ----------------------------------------

    // pixel width of the greyscale source
    localparam int PIX_W = 8;

    // address space covers up to 256 by 256
    localparam int ADDR_W = 16;

    // column and row index width
    localparam int COORD_W = 8;

    // ----------------------------------------
    // pixel types
    // ----------------------------------------
    typedef logic [PIX_W-1:0]   pixel_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COORD_W-1:0] coord_t;

endpackage

//--- hw/ig_pixel_fetch.sv
module ig_pixel_fetch #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                done_in,
    output logic                busy,
    output logic                img_rd,
    output ig_img_pkg::addr_t   img_addr,
    input  ig_img_pkg::pixel_t  img_di,
    output logic                pix_valid,
    input  logic                pix_ready,
    output ig_img_pkg::pixel_t  pix_data,
    output ig_img_pkg::coord_t  pix_x,
    output ig_img_pkg::coord_t  pix_y
);

    localparam ig_img_pkg::coord_t X_LAST = ig_img_pkg::coord_t'(IMG_W - 1);
    localparam ig_img_pkg::coord_t Y_LAST = ig_img_pkg::coord_t'(IMG_H - 1);

    logic               busy_q;
    logic               all_issued;
    logic               fresh;
    logic               slot_free;
    ig_img_pkg::coord_t x;
    ig_img_pkg::coord_t y;
    ig_img_pkg::pixel_t held;

    // slot empties this cycle, so the next read has a place to land
    assign slot_free = !pix_valid || pix_ready;
    assign img_rd    = busy_q && !all_issued && slot_free;

    // busy drops together with the done pulse
    assign busy = busy_q && !done_in;

    // memory data is valid only on the cycle after the read
    assign pix_data = fresh ? img_di : held;

    // ----------------------------------------
    // raster sequencer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q     <= 1'b0;
            all_issued <= 1'b0;
            fresh      <= 1'b0;
            pix_valid  <= 1'b0;
            x          <= '0;
            y          <= '0;
            img_addr   <= '0;
        end else begin
            fresh <= img_rd;
            if (start && !busy) begin
                busy_q     <= 1'b1;
                all_issued <= 1'b0;
                x          <= '0;
                y          <= '0;
                img_addr   <= '0;
            end else if (done_in) begin
                busy_q <= 1'b0;
            end
            if (img_rd) begin
                img_addr <= img_addr + 1'b1;
                if (x == X_LAST) begin
                    x <= '0;
                    y <= y + 1'b1;
                    if (y == Y_LAST) begin
                        all_issued <= 1'b1;
                    end
                end else begin
                    x <= x + 1'b1;
                end
            end
            // slot valid from read issue until the pixel is taken
            if (img_rd) begin
                pix_valid <= 1'b1;
            end else if (pix_ready) begin
                pix_valid <= 1'b0;
            end
        end
    end

    // coordinates follow the read, pixel is kept past its first cycle
    always_ff @(posedge clk) begin
        if (img_rd) begin
            pix_x <= x;
            pix_y <= y;
        end
        if (fresh) begin
            held <= img_di;
        end
    end

endmodule

//--- hw/ig_top.sv
module ig_top #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    output logic                           busy,
    output logic                           done,
    output logic                           img_rd,
    output ig_img_pkg::addr_t              img_addr,
    input  ig_img_pkg::pixel_t             img_di,
    output logic                           grad_wr,
    output ig_img_pkg::addr_t              grad_addr,
    output logic [ig_grad_pkg::WORD_W-1:0] grad_do,
    input  logic                           grad_ready
);

    // ----------------------------------------
    // fetch to calc
    // ----------------------------------------
    logic               pix_valid;
    logic               pix_ready;
    ig_img_pkg::pixel_t pix_data;
    ig_img_pkg::coord_t pix_x;
    ig_img_pkg::coord_t pix_y;

    // ----------------------------------------
    // calc to store
    // ----------------------------------------
    logic                    g_valid;
    logic                    g_ready;
    ig_grad_pkg::grad_word_u g_word;
    ig_img_pkg::addr_t       g_addr;

    ig_pixel_fetch #(.IMG_W(IMG_W), .IMG_H(IMG_H)) fetch_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .done_in   (done),
        .busy      (busy),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .pix_x     (pix_x),
        .pix_y     (pix_y)
    );

    ig_grad_calc #(.IMG_W(IMG_W), .IMG_H(IMG_H)) calc_i (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .g_valid   (g_valid),
        .g_ready   (g_ready),
        .g_word    (g_word),
        .g_addr    (g_addr)
    );

    ig_grad_store #(.IMG_W(IMG_W), .IMG_H(IMG_H)) store_i (
        .clk        (clk),
        .reset      (reset),
        .g_valid    (g_valid),
        .g_ready    (g_ready),
        .g_word     (g_word),
        .g_addr     (g_addr),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .grad_ready (grad_ready),
        .done       (done)
    );

endmodule

//--- tb.f
hw/ig_img_pkg.sv
hw/ig_grad_pkg.sv
hw/ig_pixel_fetch.sv
hw/ig_grad_calc.sv
hw/ig_grad_store.sv
hw/ig_top.sv
tb/ig_asserts.sv
tb/ig_tb.sv

//--- tb/ig_asserts.sv
module ig_asserts #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           done,
    input logic                           img_rd,
    input logic                           grad_wr,
    input ig_img_pkg::addr_t              grad_addr,
    input logic [ig_grad_pkg::WORD_W-1:0] grad_do,
    input logic                           grad_ready
);

    localparam int NUM_PIX = IMG_W * IMG_H;

    int fail_count = 0;

    // ----------------------------------------
    // gradient write port
    // ----------------------------------------
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        (grad_wr && !grad_ready) |=> (grad_wr && $stable(grad_addr) && $stable(grad_do)))
    else begin
        fail_count++;
        $error("gradient write changed while stalled");
    end

    addr_in_range: assert property (@(posedge clk) disable iff (reset)
        grad_wr |-> (grad_addr < NUM_PIX))
    else begin
        fail_count++;
        $error("gradient address outside the image");
    end

    // done is a single pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
    else begin
        fail_count++;
        $error("done lasted more than one cycle");
    end

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!img_rd && !grad_wr))
    else begin
        fail_count++;
        $error("memory strobe active after reset");
    end

endmodule

bind ig_top ig_asserts #(.IMG_W(IMG_W), .IMG_H(IMG_H)) asserts_i (
    .clk        (clk),
    .reset      (reset),
    .done       (done),
    .img_rd     (img_rd),
    .grad_wr    (grad_wr),
    .grad_addr  (grad_addr),
    .grad_do    (grad_do),
    .grad_ready (grad_ready)
);

//--- tb/ig_tb.sv
module ig_tb;

    localparam int IMG_W   = 16;
    localparam int IMG_H   = 8;
    localparam int NUM_PIX = IMG_W * IMG_H;

    // image pattern codes
    localparam int PAT_RAMP     = 0;
    localparam int PAT_CONST    = 1;
    localparam int PAT_RANDOM   = 2;
    localparam int PAT_EXTREMES = 3;
    // reuse the image already in memory
    localparam int PAT_SAME     = 4;

    localparam int RDY_ALWAYS = 0;
    localparam int RDY_RANDOM = 1;

    localparam int NUM_TESTS = 6;

    // ----------------------------------------
    // test table
    // ----------------------------------------
    string test_name [NUM_TESTS] = '{"ramp", "random", "random_stall", "extremes",
                                     "constant", "back_to_back"};
    int test_pat [NUM_TESTS] = '{PAT_RAMP, PAT_RANDOM, PAT_SAME, PAT_EXTREMES,
                                 PAT_CONST, PAT_RANDOM};
    int test_rdy [NUM_TESTS] = '{RDY_ALWAYS, RDY_ALWAYS, RDY_RANDOM, RDY_RANDOM,
                                 RDY_ALWAYS, RDY_ALWAYS};
    int test_reps [NUM_TESTS] = '{1, 1, 1, 1, 1, 2};

    logic                           clk;
    logic                           reset;
    logic                           start;
    logic                           busy;
    logic                           done;
    logic                           img_rd;
    ig_img_pkg::addr_t              img_addr;
    ig_img_pkg::pixel_t             img_di;
    logic                           grad_wr;
    ig_img_pkg::addr_t              grad_addr;
    logic [ig_grad_pkg::WORD_W-1:0] grad_do;
    logic                           grad_ready;

    logic [7:0]  img_mem [NUM_PIX];
    logic [19:0] grad_mem [NUM_PIX];
    int          wr_count [NUM_PIX];
    ig_img_pkg::addr_t rd_addr;
    int ready_mode;
    int done_count;
    int errors;
    int checks;
    int cycles;
    int limit;
    int total_runs;

    ig_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) dut_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .img_rd     (img_rd),
        .img_addr   (img_addr),
        .img_di     (img_di),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .grad_ready (grad_ready)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // memory models
    // ----------------------------------------

    // read data shows up in the cycle after img_rd
    always @(posedge clk) begin
        if (img_rd) begin
            rd_addr = img_addr;
            #1;
            img_di = img_mem[rd_addr];
        end
    end

    always @(posedge clk) begin
        if (grad_wr && grad_ready && grad_addr < NUM_PIX) begin
            grad_mem[grad_addr] = grad_do;
            wr_count[grad_addr] = wr_count[grad_addr] + 1;
        end
        if (done) begin
            done_count = done_count + 1;
        end
    end

    always @(posedge clk) begin
        #1;
        if (ready_mode == RDY_RANDOM) begin
            grad_ready = ($urandom_range(0, 1) == 1);
        end else begin
            grad_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the engine did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus and reference
    // ----------------------------------------
    task automatic fill_image(input int pat);
        int x;
        int y;
        for (int a = 0; a < NUM_PIX; a++) begin
            x = a % IMG_W;
            y = a / IMG_W;
            case (pat)
                PAT_RAMP:     img_mem[a] = 8'(x + 8 * y);
                PAT_CONST:    img_mem[a] = 8'h5a;
                PAT_RANDOM:   img_mem[a] = 8'($urandom_range(0, 255));
                PAT_EXTREMES: img_mem[a] = ((x + y) % 2 == 1) ? 8'hff : 8'h00;
                default:      ;
            endcase
        end
    endtask

    // right minus here and below minus here with zero past the edges
    function automatic logic [19:0] expected_word(input int a);
        int gx;
        int gy;
        gx = 0;
        gy = 0;
        if (a % IMG_W != IMG_W - 1) begin
            gx = int'(img_mem[a + 1]) - int'(img_mem[a]);
        end
        if (a / IMG_W != IMG_H - 1) begin
            gy = int'(img_mem[a + IMG_W]) - int'(img_mem[a]);
        end
        return {gx[9:0], gy[9:0]};
    endfunction

    task automatic run_image(input int t);
        logic [19:0] exp;
        for (int a = 0; a < NUM_PIX; a++) begin
            grad_mem[a] = '0;
            wr_count[a] = 0;
        end
        done_count = 0;
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        // a second start while busy must be ignored
        repeat (3) @(posedge clk);
        #1;
        assert (busy) else begin
            errors++;
            $display("busy is not high after start in test %s", test_name[t]);
        end
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        while (done_count == 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
        assert (done_count == 1) else begin
            errors++;
            $display("error %s done pulses expected 1 actual %0d", test_name[t], done_count);
        end
        assert (!busy) else begin
            errors++;
            $display("busy is still high after done in test %s", test_name[t]);
        end
        for (int a = 0; a < NUM_PIX; a++) begin
            exp = expected_word(a);
            checks++;
            assert (grad_mem[a] == exp) else begin
                errors++;
                $display("error %s addr %0d expected %h actual %h",
                         test_name[t], a, exp, grad_mem[a]);
            end
            assert (wr_count[a] == 1) else begin
                errors++;
                $display("error %s addr %0d expected 1 write actual %0d",
                         test_name[t], a, wr_count[a]);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h2812));
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        img_di     = '0;
        grad_ready = 1'b1;
        ready_mode = RDY_ALWAYS;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        total_runs = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_runs += test_reps[t];
        end
        limit = total_runs * (4 * NUM_PIX + 100);
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            ready_mode = test_rdy[t];
            for (int r = 0; r < test_reps[t]; r++) begin
                fill_image(test_pat[t]);
                run_image(t);
            end
        end
        errors += dut_i.asserts_i.fail_count;
        $display("runs %0d checks %0d assertion failures %0d errors %0d",
                 total_runs, checks, dut_i.asserts_i.fail_count, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
